// File: verilog/memhost_pkg.sv
/* Memory host shared definitions */
`default_nettype none

package memhost_pkg;

    // Memory geometry
    localparam int DATA_WIDTH = 16;
    localparam int ADDR_WIDTH = 5;     // One bit more than the depth needs
    localparam int MEM_DEPTH  = 16;
    localparam int MEM_IDX_W  = $clog2(MEM_DEPTH);

    // Pattern generator
    localparam int LFSR_WIDTH = 32;
    localparam logic [LFSR_WIDTH-1:0] MEM_PATTERN = 32'hDEADBEEF;

    // Feedback taps at bits 31, 21, 1 and 0
    localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = (32'h1 << 31) | (32'h1 << 21) |
                                                  (32'h1 << 1) | (32'h1 << 0);

    // Trigger byte sequence, first then second
    localparam logic [7:0] TRIG_FIRST  = 8'hAA;
    localparam logic [7:0] TRIG_SECOND = 8'h55;

    // Request kind
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } op_t;

    // Decode stage output
    typedef struct packed {
        logic                  valid;
        op_t                   op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic                  in_range;   // Address below MEM_DEPTH
    } req_t;

    // Access stage output
    typedef struct packed {
        logic                  valid;
        op_t                   op;
        logic [DATA_WIDTH-1:0] rdata;      // Zero unless a good read
        logic                  error;      // Out-of-range request
    } acc_t;

endpackage

`default_nettype wire

// File: verilog/pattern_lfsr.sv
/* Pattern generator LFSR */
`timescale 1ns/1ps
`default_nettype none

module pattern_lfsr
    import memhost_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       advance,
    output logic [7:0] trigger_byte
);

    logic [LFSR_WIDTH-1:0] state;
    logic [LFSR_WIDTH-1:0] state_next;
    logic                  feedback;

    // Fibonacci form, XOR of the tapped bits
    assign feedback   = ^(state & LFSR_TAPS);
    assign state_next = {state[LFSR_WIDTH-2:0], feedback};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MEM_PATTERN;
        end else if (advance) begin
            state <= state_next;
        end
    end

    // Low byte of the state after this advance, seen by the detector at the same edge
    assign trigger_byte = state_next[7:0];

endmodule

`default_nettype wire

// File: verilog/trigger_detect.sv
/* Byte sequence trigger detector */
`timescale 1ns/1ps
`default_nettype none

module trigger_detect
    import memhost_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       advance,
    input  logic [7:0] trigger_byte,
    output logic       force_reset
);

    logic armed;     // First byte of the sequence seen
    logic hit_first;
    logic hit_second;

    assign hit_first  = (trigger_byte == TRIG_FIRST);
    assign hit_second = (trigger_byte == TRIG_SECOND);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed       <= 1'b0;
            force_reset <= 1'b0;
        end else begin
            force_reset <= 1'b0;   // One cycle pulse only
            if (force_reset) begin
                // Flush clears the recognizer along with the pipeline
                armed <= 1'b0;
            end else if (advance) begin
                if (armed && hit_second) begin
                    force_reset <= 1'b1;
                    armed       <= 1'b0;
                end else begin
                    armed <= hit_first;   // Any other byte disarms
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/req_decode.sv
/* Request decode stage */
`timescale 1ns/1ps
`default_nettype none

module req_decode
    import memhost_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic [ADDR_WIDTH-1:0] address,
    input  logic [DATA_WIDTH-1:0] write_data,
    input  logic                  write_enable,
    input  logic                  read_enable,
    output logic                  accept,
    output req_t                  req
);

    logic                  valid_q;
    op_t                   op_q;
    op_t                   op_d;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic                  in_range_q;

    assign accept = write_enable | read_enable;

    // Write wins when both strobes are high
    assign op_d = write_enable ? OP_WRITE :
                  read_enable  ? OP_READ  : OP_NONE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            op_q    <= OP_NONE;
        end else if (flush) begin
            valid_q <= 1'b0;
            op_q    <= OP_NONE;
        end else begin
            valid_q <= accept;
            op_q    <= op_d;
        end
    end

    // Payload, meaningful only with valid
    always_ff @(posedge clk) begin
        addr_q     <= address;
        wdata_q    <= write_data;
        in_range_q <= (address < ADDR_WIDTH'(MEM_DEPTH));
    end

    assign req = '{valid: valid_q, op: op_q, addr: addr_q, wdata: wdata_q,
                   in_range: in_range_q};

endmodule

`default_nettype wire

// File: verilog/mem_access.sv
/* Memory access stage */
`timescale 1ns/1ps
`default_nettype none

module mem_access
    import memhost_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  req_t req,
    output acc_t acc
);

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic [MEM_IDX_W-1:0]  idx;
    logic                  do_write;
    logic                  do_read;

    logic                  valid_q;
    op_t                   op_q;
    logic                  error_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    // Upper address bit only matters for the range check
    assign idx      = req.addr[MEM_IDX_W-1:0];
    assign do_write = req.valid && req.in_range && (req.op == OP_WRITE);
    assign do_read  = req.valid && req.in_range && (req.op == OP_READ);

    // Array is wiped by reset and by a flush alike
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (do_write) begin
            mem[idx] <= req.wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
            op_q    <= OP_NONE;
            error_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;   // Drops whatever was in flight
            op_q    <= OP_NONE;
            error_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
            op_q    <= req.op;
            error_q <= ~req.in_range;
        end
    end

    // Read word, zero for writes and errored requests
    always_ff @(posedge clk) begin
        if (do_read) begin
            rdata_q <= mem[idx];
        end else begin
            rdata_q <= '0;
        end
    end

    assign acc = '{valid: valid_q, op: op_q, rdata: rdata_q, error: error_q};

endmodule

`default_nettype wire

// File: verilog/resp_stage.sv
/* Response stage */
`timescale 1ns/1ps
`default_nettype none

module resp_stage
    import memhost_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  acc_t                  acc,
    output logic [DATA_WIDTH-1:0] read_data,
    output logic                  read_valid,
    output logic                  write_ack,
    output logic                  memory_error
);

    logic is_write;
    logic is_read;

    assign is_write = acc.valid && (acc.op == OP_WRITE);
    assign is_read  = acc.valid && (acc.op == OP_READ);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_data    <= '0;
            read_valid   <= 1'b0;
            write_ack    <= 1'b0;
            memory_error <= 1'b0;
        end else if (flush) begin
            read_data    <= '0;
            read_valid   <= 1'b0;
            write_ack    <= 1'b0;
            memory_error <= 1'b0;
        end else begin
            // Pulses are mutually exclusive
            write_ack    <= is_write && !acc.error;
            read_valid   <= is_read && !acc.error;
            memory_error <= acc.valid && acc.error;
            if (is_read) begin
                read_data <= acc.error ? '0 : acc.rdata;   // Held until the next read
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/memory_host.sv
/* Memory host top level */
`timescale 1ns/1ps
`default_nettype none

module memory_host
    import memhost_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [ADDR_WIDTH-1:0] address,
    input  logic [DATA_WIDTH-1:0] write_data,
    input  logic                  write_enable,
    input  logic                  read_enable,
    output logic [DATA_WIDTH-1:0] read_data,
    output logic                  read_valid,
    output logic                  write_ack,
    output logic                  memory_error
);

    req_t       req;
    acc_t       acc;
    logic       accept;
    logic [7:0] trigger_byte;
    logic       force_reset;   // Flushes every stage

    req_decode i_req_decode (
        .clk          (clk),
        .rst          (rst),
        .flush        (force_reset),
        .address      (address),
        .write_data   (write_data),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .accept       (accept),
        .req          (req)
    );

    mem_access i_mem_access (
        .clk   (clk),
        .rst   (rst),
        .flush (force_reset),
        .req   (req),
        .acc   (acc)
    );

    resp_stage i_resp_stage (
        .clk          (clk),
        .rst          (rst),
        .flush        (force_reset),
        .acc          (acc),
        .read_data    (read_data),
        .read_valid   (read_valid),
        .write_ack    (write_ack),
        .memory_error (memory_error)
    );

    // Advances on every accepted request
    pattern_lfsr i_pattern_lfsr (
        .clk          (clk),
        .rst          (rst),
        .advance      (accept),
        .trigger_byte (trigger_byte)
    );

    trigger_detect i_trigger_detect (
        .clk          (clk),
        .rst          (rst),
        .advance      (accept),
        .trigger_byte (trigger_byte),
        .force_reset  (force_reset)
    );

endmodule

`default_nettype wire

// File: tb/tb_memory_host.sv
/* Memory host directed testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_memory_host
    import memhost_pkg::*;
;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int N_RAND_WR    = 24;
    localparam int N_OOR        = 8;
    localparam int N_B2B        = 64;
    localparam int TRIG_LIMIT   = 200000;

    // Cycle budget of every test in order plus drain
    localparam int TEST_CYCLES = RESET_CYCLES + (3 + MEM_DEPTH) + (N_RAND_WR + 4 + MEM_DEPTH)
                               + (N_OOR + MEM_DEPTH) + N_B2B
                               + (3 + TRIG_LIMIT + 3 + MEM_DEPTH + 8) + 4;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 10 + 100;

    // One cycle of expected DUT outputs
    typedef struct packed {
        logic                  write_ack;
        logic                  read_valid;
        logic                  memory_error;
        logic [DATA_WIDTH-1:0] read_data;
    } exp_resp_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] write_data;
    logic                  write_enable;
    logic                  read_enable;
    logic [DATA_WIDTH-1:0] read_data;
    logic                  read_valid;
    logic                  write_ack;
    logic                  memory_error;

    // Reference model state
    exp_resp_t             expect_q[$];   // Outputs per edge three ahead
    logic [DATA_WIDTH-1:0] mirror [MEM_DEPTH];
    logic [DATA_WIDTH-1:0] held_rdata;
    logic [31:0]           lfsr_model;
    logic                  armed_model;
    logic                  drop_next;     // Next sampled request meets the flush
    logic [31:0]           rng;

    memory_host i_memory_host (
        .clk          (clk),
        .rst          (rst),
        .address      (address),
        .write_data   (write_data),
        .write_enable (write_enable),
        .read_enable  (read_enable),
        .read_data    (read_data),
        .read_valid   (read_valid),
        .write_ack    (write_ack),
        .memory_error (memory_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Shift left with feedback from bits 31, 21, 1 and 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Expected outputs three edges after the request is driven
    task automatic predict(input logic we, input logic re, input logic [ADDR_WIDTH-1:0] a,
                           input logic [DATA_WIDTH-1:0] d);
        exp_resp_t            r;
        logic                 fire;
        logic [MEM_IDX_W-1:0] idx;
        r    = '0;
        fire = 1'b0;
        idx  = a[MEM_IDX_W-1:0];
        if (we || re) begin
            lfsr_model = lfsr_step(lfsr_model);
        end
        if (drop_next) begin
            drop_next   = 1'b0;   // Sampled on the flush edge so the byte is ignored
            armed_model = 1'b0;
        end else if (we || re) begin
            if (armed_model && lfsr_model[7:0] == TRIG_SECOND) begin
                fire = 1'b1;
            end else begin
                armed_model = (lfsr_model[7:0] == TRIG_FIRST);
                if (int'(a) >= MEM_DEPTH) begin
                    r.memory_error = 1'b1;
                    if (!we) begin
                        held_rdata = '0;
                    end
                end else if (we) begin
                    mirror[idx] = d;   // Write wins over read
                    r.write_ack = 1'b1;
                end else begin
                    held_rdata   = mirror[idx];
                    r.read_valid = 1'b1;
                end
            end
        end
        if (fire) begin
            // Flush lands two edges on and wipes the previous response too
            armed_model = 1'b0;
            drop_next   = 1'b1;
            foreach (mirror[i]) begin
                mirror[i] = '0;
            end
            held_rdata = '0;
            expect_q[expect_q.size() - 1] = '0;
        end
        r.read_data = held_rdata;
        expect_q.push_back(r);
    endtask

    // One clock cycle and a compare of the outputs of this edge
    task automatic issue(input logic we, input logic re, input logic [ADDR_WIDTH-1:0] a,
                         input logic [DATA_WIDTH-1:0] d);
        exp_resp_t exp;
        @(posedge clk);
        write_enable <= we;
        read_enable  <= re;
        address      <= a;
        write_data   <= d;
        predict(we, re, a, d);
        @(negedge clk);
        exp = expect_q.pop_front();
        check_flag("write_ack", exp.write_ack, write_ack);
        check_flag("read_valid", exp.read_valid, read_valid);
        check_flag("memory_error", exp.memory_error, memory_error);
        check_data("read_data", exp.read_data, read_data);
    endtask

    task automatic idle(input int n);
        repeat (n) issue(1'b0, 1'b0, '0, '0);
    endtask

    task automatic read_all();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            issue(1'b0, 1'b1, ADDR_WIDTH'(a), '0);
        end
    endtask

    task automatic reset_state();
        idle(3);
        read_all();   // All zeros with read_valid
    endtask

    task automatic write_read_back();
        for (int i = 0; i < N_RAND_WR; i++) begin
            rng = xorshift32(rng);
            issue(1'b1, 1'b0, {1'b0, rng[19:16]}, rng[DATA_WIDTH-1:0]);
        end
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            issue(1'b1, 1'b1, {1'b0, rng[19:16]}, rng[DATA_WIDTH-1:0]);   // Both strobes
        end
        read_all();
    endtask

    task automatic out_of_range();
        for (int i = 0; i < N_OOR; i++) begin
            rng = xorshift32(rng);
            issue(rng[20] | rng[21], !rng[20], {1'b1, rng[19:16]}, rng[DATA_WIDTH-1:0]);
        end
        read_all();   // Contents unchanged
    endtask

    task automatic back_to_back();
        logic                  we;
        logic                  re;
        logic [ADDR_WIDTH-1:0] a;
        for (int i = 0; i < N_B2B; i++) begin
            rng = xorshift32(rng);
            we  = (rng[31:30] == 2'd0) || (rng[31:30] == 2'd2);
            re  = (rng[31:30] != 2'd0);
            a   = {(rng[25:24] == 2'd0), rng[19:16]};   // Mostly in range
            issue(we, re, a, rng[DATA_WIDTH-1:0]);
        end
    endtask

    task automatic trigger_flush();
        logic [31:0] s;
        logic        arm;
        logic        found;
        int          steps;
        idle(3);
        s     = lfsr_model;
        arm   = armed_model;
        found = 1'b0;
        steps = 0;
        while (!found && steps < TRIG_LIMIT) begin
            steps++;
            s = lfsr_step(s);
            if (arm && s[7:0] == TRIG_SECOND) begin
                found = 1'b1;
            end else begin
                arm = (s[7:0] == TRIG_FIRST);
            end
        end
        if (!found) begin
            abort_run($sformatf("no trigger sequence found within %0d requests", TRIG_LIMIT));
        end
        for (int i = 0; i < steps; i++) begin
            rng = xorshift32(rng);
            issue(1'b1, 1'b0, {1'b0, rng[19:16]}, rng[DATA_WIDTH-1:0] | DATA_WIDTH'(1));
        end
        idle(3);   // Lost responses must stay absent
        read_all();
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, 1'b0, ADDR_WIDTH'(i), DATA_WIDTH'(16'h1234 + i));
        end
        for (int i = 0; i < 4; i++) begin
            issue(1'b0, 1'b1, ADDR_WIDTH'(i), '0);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("timeout after %0d cycles without finishing", WATCHDOG_CYCLES));
    end

    initial begin
        rst          = 1'b1;
        address      = '0;
        write_data   = '0;
        write_enable = 1'b0;
        read_enable  = 1'b0;
        held_rdata   = '0;
        lfsr_model   = MEM_PATTERN;
        armed_model  = 1'b0;
        drop_next    = 1'b0;
        rng          = 32'hdf15_018b;
        foreach (mirror[i]) begin
            mirror[i] = '0;
        end
        repeat (3) expect_q.push_back('0);   // Idle outputs out of reset
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        write_read_back();
        out_of_range();
        back_to_back();
        trigger_flush();
        idle(4);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: memory_host.f
verilog/memhost_pkg.sv
verilog/pattern_lfsr.sv
verilog/trigger_detect.sv
verilog/req_decode.sv
verilog/mem_access.sv
verilog/resp_stage.sv
verilog/memory_host.sv
tb/tb_memory_host.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory host testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary --top-module tb_memory_host -f memory_host.f -o sim_memory_host \
    && { ./obj_dir/sim_memory_host > sim.log 2>&1 || true; } \
    && grep -q "Test passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
